//--- sim.f
source/cpu_pkg.sv
source/datapath_ctrl_if.sv
source/instruction_sequencer.sv
source/two_word_decode.sv
source/instruction_decode.sv
source/cpu_control.sv
tb/clock_gen.sv
tb/cpu_control_assertions.sv
tb/cpu_control_tb.sv

//--- source/cpu_control.sv
`timescale 1ns/1ps

module cpu_control (
    input logic clock,
    input logic reset,
    input cpu_pkg::nibble_t data,
    input logic take_branch,
    input logic reg_is_zero,
    output logic sync,
    output cpu_pkg::phase_t cycle,
    output cpu_pkg::nibble_t inst_operand,
    output logic clear_carry,
    output logic write_carry,
    output logic clear_accumulator,
    output logic write_accumulator,
    output cpu_pkg::acc_in_sel_t acc_input_sel,
    output logic write_register,
    output cpu_pkg::reg_in_sel_t reg_input_sel,
    output cpu_pkg::alu_op_t alu_op,
    output cpu_pkg::alu_in0_sel_t alu_in0_sel,
    output cpu_pkg::alu_in1_sel_t alu_in1_sel,
    output cpu_pkg::alu_cin_sel_t alu_cin_sel,
    output cpu_pkg::pc_next_sel_t pc_next_sel,
    output cpu_pkg::pc_nibble_t pc_write_enable,
    output cpu_pkg::pc_stack_op_t pc_control,
    output logic reg_out_enable
);
    import cpu_pkg::*;

    inst_t inst;
    logic two_word;
    logic two_word_start;

    datapath_ctrl_if word2_ctrl ();
    datapath_ctrl_if ctrl ();

    instruction_sequencer u_sequencer (
        .clock          (clock),
        .reset          (reset),
        .data           (data),
        .two_word_start (two_word_start),
        .operand_sel    (ctrl.operand_sel),
        .phase          (cycle),
        .sync           (sync),
        .inst           (inst),
        .two_word       (two_word),
        .inst_operand   (inst_operand)
    );

    instruction_decode u_decode (
        .phase          (cycle),
        .inst           (inst),
        .two_word       (two_word),
        .word2_ctrl     (word2_ctrl.sink),
        .ctrl           (ctrl.decoder),
        .two_word_start (two_word_start)
    );

    two_word_decode u_two_word (
        .phase       (cycle),
        .inst        (inst),
        .take_branch (take_branch),
        .reg_is_zero (reg_is_zero),
        .ctrl        (word2_ctrl.decoder)
    );

    // Datapath controls leave the chip as plain ports
    assign clear_carry = ctrl.clear_carry;
    assign write_carry = ctrl.write_carry;
    assign clear_accumulator = ctrl.clear_accumulator;
    assign write_accumulator = ctrl.write_accumulator;
    assign acc_input_sel = ctrl.acc_input_sel;
    assign write_register = ctrl.write_register;
    assign reg_input_sel = ctrl.reg_input_sel;
    assign alu_op = ctrl.alu_op;
    assign alu_in0_sel = ctrl.alu_in0_sel;
    assign alu_in1_sel = ctrl.alu_in1_sel;
    assign alu_cin_sel = ctrl.alu_cin_sel;
    assign pc_next_sel = ctrl.pc_next_sel;
    assign pc_write_enable = ctrl.pc_write_enable;
    assign pc_control = ctrl.pc_control;
    assign reg_out_enable = ctrl.reg_out_enable;

endmodule

//--- source/cpu_pkg.sv
package cpu_pkg;

    localparam int NIBBLE_W = 4;
    localparam int INST_W = 2 * NIBBLE_W;

    typedef logic [NIBBLE_W-1:0] nibble_t;
    typedef logic [INST_W-1:0] inst_t;

    // Subcycles of one system cycle
    typedef enum logic [2:0] {
        A1, A2, A3, M1, M2, X1, X2, X3
    } phase_t;

    // High nibble of the instruction byte
    typedef enum logic [3:0] {
        OP_NOP, OP_JCN, OP_FIM, OP_FIN,
        OP_JUN, OP_JMS, OP_INC, OP_ISZ,
        OP_ADD, OP_SUB, OP_LD, OP_XCH,
        OP_BBL, OP_LDM, OP_IO, OP_ACC
    } opcode_t;

    // Low nibble within the accumulator group
    typedef enum logic [3:0] {
        ACC_CLB, ACC_CLC, ACC_IAC, ACC_CMC,
        ACC_CMA, ACC_RAL, ACC_RAR, ACC_TCC,
        ACC_DAC, ACC_TCS, ACC_STC, ACC_DAA,
        ACC_KBP
    } acc_op_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_PASS, ALU_ROL, ALU_ROR, ALU_DEC_A, ALU_LG2_1
    } alu_op_t;

    typedef enum logic [2:0] {
        IN0_REG, IN0_REG_INV, IN0_ACC, IN0_ACC_INV, IN0_DATA
    } alu_in0_sel_t;

    typedef enum logic [1:0] {
        IN1_ACC, IN1_ONE, IN1_ONE_INV
    } alu_in1_sel_t;

    typedef enum logic [1:0] {
        CIN_ZERO, CIN_ONE, CIN_CARRY, CIN_CARRY_INV
    } alu_cin_sel_t;

    typedef enum logic [2:0] {
        ACC_IN_FROM_ALU, ACC_IN_FROM_REG, ACC_IN_FROM_IMM,
        ACC_IN_FROM_CARRY, ACC_IN_FROM_CARRY2
    } acc_in_sel_t;

    typedef enum logic [1:0] {
        REG_IN_FROM_ALU, REG_IN_FROM_ACC, REG_IN_FROM_DATA
    } reg_in_sel_t;

    typedef enum logic [1:0] {
        PC_FROM_DATA, PC_FROM_INST, PC_FROM_REG
    } pc_next_sel_t;

    typedef enum logic [1:0] {
        STACK_NOP, STACK_PUSH, STACK_POP
    } pc_stack_op_t;

    // PARTNER flips bit 0 to reach the other register of a pair
    typedef enum logic [1:0] {
        OPND_INST, OPND_PARTNER, OPND_R0, OPND_R1
    } operand_sel_t;

    // One enable per PC nibble
    typedef logic [2:0] pc_nibble_t;
    localparam int PC_LOW = 0;
    localparam int PC_MID = 1;
    localparam int PC_HIGH = 2;

endpackage

//--- source/datapath_ctrl_if.sv
`timescale 1ns/1ps

interface datapath_ctrl_if;
    import cpu_pkg::*;

    // Accumulator and carry
    logic clear_carry;
    logic write_carry;
    logic clear_accumulator;
    logic write_accumulator;
    acc_in_sel_t acc_input_sel;

    // Register file
    logic write_register;
    reg_in_sel_t reg_input_sel;
    logic reg_out_enable;
    operand_sel_t operand_sel;

    // ALU
    alu_op_t alu_op;
    alu_in0_sel_t alu_in0_sel;
    alu_in1_sel_t alu_in1_sel;
    alu_cin_sel_t alu_cin_sel;

    // Program counter and address stack
    pc_next_sel_t pc_next_sel;
    pc_nibble_t pc_write_enable;
    pc_stack_op_t pc_control;

    modport decoder (
        output clear_carry, write_carry, clear_accumulator, write_accumulator,
        output acc_input_sel, write_register, reg_input_sel, reg_out_enable, operand_sel,
        output alu_op, alu_in0_sel, alu_in1_sel, alu_cin_sel,
        output pc_next_sel, pc_write_enable, pc_control
    );

    modport sink (
        input clear_carry, write_carry, clear_accumulator, write_accumulator,
        input acc_input_sel, write_register, reg_input_sel, reg_out_enable, operand_sel,
        input alu_op, alu_in0_sel, alu_in1_sel, alu_cin_sel,
        input pc_next_sel, pc_write_enable, pc_control
    );

endinterface

//--- source/instruction_decode.sv
`timescale 1ns/1ps

module instruction_decode (
    input cpu_pkg::phase_t phase,
    input cpu_pkg::inst_t inst,
    input logic two_word,
    datapath_ctrl_if.sink word2_ctrl,
    datapath_ctrl_if.decoder ctrl,
    output logic two_word_start
);
    import cpu_pkg::*;

    opcode_t opcode;
    acc_op_t acc_op;

    assign opcode = opcode_t'(inst[7:4]);
    assign acc_op = acc_op_t'(inst[3:0]);

    always_comb begin
        ctrl.clear_carry = 1'b0;
        ctrl.write_carry = 1'b0;
        ctrl.clear_accumulator = 1'b0;
        ctrl.write_accumulator = 1'b0;
        ctrl.acc_input_sel = ACC_IN_FROM_ALU;
        ctrl.write_register = 1'b0;
        ctrl.reg_input_sel = REG_IN_FROM_ALU;
        ctrl.reg_out_enable = 1'b0;
        ctrl.operand_sel = OPND_INST;
        ctrl.alu_op = ALU_ADD;
        ctrl.alu_in0_sel = IN0_REG;
        ctrl.alu_in1_sel = IN1_ACC;
        ctrl.alu_cin_sel = CIN_ZERO;
        ctrl.pc_next_sel = PC_FROM_DATA;
        ctrl.pc_write_enable = '0;
        ctrl.pc_control = STACK_NOP;
        two_word_start = 1'b0;

        if (two_word) begin
            // Second system cycle is decoded separately
            ctrl.clear_carry = word2_ctrl.clear_carry;
            ctrl.write_carry = word2_ctrl.write_carry;
            ctrl.clear_accumulator = word2_ctrl.clear_accumulator;
            ctrl.write_accumulator = word2_ctrl.write_accumulator;
            ctrl.acc_input_sel = word2_ctrl.acc_input_sel;
            ctrl.write_register = word2_ctrl.write_register;
            ctrl.reg_input_sel = word2_ctrl.reg_input_sel;
            ctrl.reg_out_enable = word2_ctrl.reg_out_enable;
            ctrl.operand_sel = word2_ctrl.operand_sel;
            ctrl.alu_op = word2_ctrl.alu_op;
            ctrl.alu_in0_sel = word2_ctrl.alu_in0_sel;
            ctrl.alu_in1_sel = word2_ctrl.alu_in1_sel;
            ctrl.alu_cin_sel = word2_ctrl.alu_cin_sel;
            ctrl.pc_next_sel = word2_ctrl.pc_next_sel;
            ctrl.pc_write_enable = word2_ctrl.pc_write_enable;
            ctrl.pc_control = word2_ctrl.pc_control;
        end else begin
            case (phase)
                A3: begin
                    // BBL returns through the address stack
                    if (opcode == OP_BBL) begin
                        ctrl.pc_control = STACK_POP;
                    end
                end
                X1: begin
                    case (opcode)
                        OP_JCN, OP_JUN, OP_JMS: two_word_start = 1'b1;
                        // Odd FIM slot is SRC, which is not supported
                        OP_FIM: two_word_start = !inst[0];
                        OP_FIN: begin
                            if (inst[0]) begin
                                // JIN, low PC nibble from the odd register
                                ctrl.pc_write_enable[PC_LOW] = 1'b1;
                                ctrl.pc_next_sel = PC_FROM_REG;
                            end else begin
                                two_word_start = 1'b1;
                            end
                        end
                        OP_INC, OP_ISZ: begin
                            ctrl.alu_in0_sel = IN0_REG;
                            ctrl.alu_in1_sel = IN1_ONE;
                            ctrl.alu_cin_sel = CIN_ZERO;
                            ctrl.reg_input_sel = REG_IN_FROM_ALU;
                            ctrl.write_register = 1'b1;
                            // ISZ branches on the result in its second word
                            two_word_start = (opcode == OP_ISZ);
                        end
                        OP_ADD, OP_SUB: begin
                            ctrl.alu_in0_sel = (opcode == OP_SUB) ? IN0_REG_INV : IN0_REG;
                            ctrl.alu_in1_sel = IN1_ACC;
                            ctrl.alu_cin_sel = (opcode == OP_SUB) ? CIN_CARRY_INV : CIN_CARRY;
                            ctrl.acc_input_sel = ACC_IN_FROM_ALU;
                            ctrl.write_accumulator = 1'b1;
                            ctrl.write_carry = 1'b1;
                        end
                        OP_LD, OP_XCH: begin
                            ctrl.acc_input_sel = ACC_IN_FROM_REG;
                            ctrl.write_accumulator = 1'b1;
                            // The old accumulator goes to the register for XCH
                            ctrl.reg_input_sel = REG_IN_FROM_ACC;
                            ctrl.write_register = (opcode == OP_XCH);
                        end
                        OP_BBL, OP_LDM: begin
                            ctrl.acc_input_sel = ACC_IN_FROM_IMM;
                            ctrl.write_accumulator = 1'b1;
                        end
                        OP_ACC: begin
                            case (acc_op)
                                ACC_CLB: begin
                                    ctrl.clear_accumulator = 1'b1;
                                    ctrl.clear_carry = 1'b1;
                                end
                                ACC_CLC: ctrl.clear_carry = 1'b1;
                                ACC_CMC, ACC_STC: begin
                                    // Carry out of a PASS is the selected carry in
                                    ctrl.alu_op = ALU_PASS;
                                    ctrl.alu_cin_sel =
                                        (acc_op == ACC_STC) ? CIN_ONE : CIN_CARRY_INV;
                                    ctrl.write_carry = 1'b1;
                                end
                                ACC_TCC, ACC_TCS: begin
                                    ctrl.acc_input_sel = (acc_op == ACC_TCS) ?
                                        ACC_IN_FROM_CARRY2 : ACC_IN_FROM_CARRY;
                                    ctrl.write_accumulator = 1'b1;
                                    ctrl.clear_carry = 1'b1;
                                end
                                ACC_IAC, ACC_CMA, ACC_RAL, ACC_RAR,
                                ACC_DAC, ACC_DAA, ACC_KBP: begin
                                    ctrl.alu_in0_sel = IN0_ACC;
                                    ctrl.acc_input_sel = ACC_IN_FROM_ALU;
                                    ctrl.write_accumulator = 1'b1;
                                    // CMA and KBP leave the carry alone
                                    ctrl.write_carry = (acc_op != ACC_CMA) && (acc_op != ACC_KBP);
                                    case (acc_op)
                                        ACC_IAC: ctrl.alu_in1_sel = IN1_ONE;
                                        ACC_CMA: begin
                                            ctrl.alu_op = ALU_PASS;
                                            ctrl.alu_in0_sel = IN0_ACC_INV;
                                        end
                                        ACC_RAL: begin
                                            ctrl.alu_op = ALU_ROL;
                                            ctrl.alu_cin_sel = CIN_CARRY;
                                        end
                                        ACC_RAR: begin
                                            ctrl.alu_op = ALU_ROR;
                                            ctrl.alu_cin_sel = CIN_CARRY;
                                        end
                                        ACC_DAC: begin
                                            // A + 1110 + 1 leaves borrow as inverted carry
                                            ctrl.alu_in1_sel = IN1_ONE_INV;
                                            ctrl.alu_cin_sel = CIN_ONE;
                                        end
                                        ACC_DAA: begin
                                            ctrl.alu_op = ALU_DEC_A;
                                            ctrl.alu_cin_sel = CIN_CARRY;
                                        end
                                        default: ctrl.alu_op = ALU_LG2_1;
                                    endcase
                                end
                                default: ;
                            endcase
                        end
                        default: ;
                    endcase
                end
                X2: begin
                    // JIN, middle PC nibble from the even register
                    if (opcode == OP_FIN && inst[0]) begin
                        ctrl.operand_sel = OPND_PARTNER;
                        ctrl.pc_write_enable[PC_MID] = 1'b1;
                        ctrl.pc_next_sel = PC_FROM_REG;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

//--- source/instruction_sequencer.sv
`timescale 1ns/1ps

module instruction_sequencer (
    input logic clock,
    input logic reset,
    input cpu_pkg::nibble_t data,
    input logic two_word_start,
    input cpu_pkg::operand_sel_t operand_sel,
    output cpu_pkg::phase_t phase,
    output logic sync,
    output cpu_pkg::inst_t inst,
    output logic two_word,
    output cpu_pkg::nibble_t inst_operand
);
    import cpu_pkg::*;

    // Free-running subcycle counter, X3 wraps to A1
    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= A1;
        end else begin
            phase <= phase_t'(phase + 3'd1);
        end
    end

    // Marks the start of the next system cycle
    assign sync = (phase != X3);

    // Opcode nibble arrives in M1, operand nibble in M2
    // The second word of a two-word instruction is address or data, not an opcode
    always_ff @(posedge clock) begin
        if (reset) begin
            inst <= '0;
        end else if (!two_word) begin
            if (phase == M1) begin
                inst[7:4] <= data;
            end else if (phase == M2) begin
                inst[3:0] <= data;
            end
        end
    end

    // Set at the end of X1 of the first word, cleared at the end of X1 of the second
    always_ff @(posedge clock) begin
        if (reset) begin
            two_word <= 1'b0;
        end else if (phase == X1) begin
            two_word <= !two_word && two_word_start;
        end
    end

    always_comb begin
        case (operand_sel)
            OPND_PARTNER: inst_operand = {inst[3:1], ~inst[0]};
            OPND_R0:      inst_operand = 4'h0;
            OPND_R1:      inst_operand = 4'h1;
            default:      inst_operand = inst[3:0];
        endcase
    end

endmodule

//--- source/two_word_decode.sv
`timescale 1ns/1ps

module two_word_decode (
    input cpu_pkg::phase_t phase,
    input cpu_pkg::inst_t inst,
    input logic take_branch,
    input logic reg_is_zero,
    datapath_ctrl_if.decoder ctrl
);
    import cpu_pkg::*;

    opcode_t opcode;
    logic jump;
    logic long_jump;
    logic pair_fetch;

    assign opcode = opcode_t'(inst[7:4]);

    // Which part of the second word this instruction consumes
    always_comb begin
        jump = 1'b0;
        long_jump = 1'b0;
        pair_fetch = 1'b0;
        case (opcode)
            OP_JCN: jump = take_branch;
            OP_ISZ: jump = !reg_is_zero;
            OP_JUN, OP_JMS: begin
                jump = 1'b1;
                long_jump = 1'b1;
            end
            OP_FIM, OP_FIN: pair_fetch = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        ctrl.clear_carry = 1'b0;
        ctrl.write_carry = 1'b0;
        ctrl.clear_accumulator = 1'b0;
        ctrl.write_accumulator = 1'b0;
        ctrl.acc_input_sel = ACC_IN_FROM_ALU;
        ctrl.write_register = 1'b0;
        ctrl.reg_input_sel = REG_IN_FROM_ALU;
        ctrl.reg_out_enable = 1'b0;
        ctrl.operand_sel = OPND_INST;
        ctrl.alu_op = ALU_ADD;
        ctrl.alu_in0_sel = IN0_REG;
        ctrl.alu_in1_sel = IN1_ACC;
        ctrl.alu_cin_sel = CIN_ZERO;
        ctrl.pc_next_sel = PC_FROM_DATA;
        ctrl.pc_write_enable = '0;
        ctrl.pc_control = STACK_NOP;

        case (phase)
            A1, A2: begin
                // FIN puts the pair R0R1 out as the fetch address, R1 first
                if (opcode == OP_FIN) begin
                    ctrl.reg_out_enable = 1'b1;
                    ctrl.operand_sel = (phase == A1) ? OPND_R1 : OPND_R0;
                end
            end
            A3: begin
                // Save the return address before the PC is overwritten
                if (opcode == OP_JMS) begin
                    ctrl.pc_control = STACK_PUSH;
                end
            end
            M1, M2: begin
                if (jump) begin
                    ctrl.pc_next_sel = PC_FROM_DATA;
                    ctrl.pc_write_enable[PC_MID] = (phase == M1);
                    ctrl.pc_write_enable[PC_LOW] = (phase == M2);
                end
                if (pair_fetch) begin
                    ctrl.reg_input_sel = REG_IN_FROM_DATA;
                    ctrl.write_register = 1'b1;
                    ctrl.operand_sel = (phase == M2) ? OPND_PARTNER : OPND_INST;
                end
            end
            X1: begin
                // Top PC nibble comes from the first word's operand
                if (long_jump) begin
                    ctrl.pc_next_sel = PC_FROM_INST;
                    ctrl.pc_write_enable[PC_HIGH] = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- tb/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clock
);
    localparam time HALF_PERIOD = 10ns;

    initial begin
        clock = 1'b0;
    end

    // 20 ns period
    always #(HALF_PERIOD) clock = ~clock;

endmodule

//--- tb/control_patterns.txt
// One clock per line: data take_branch reg_is_zero _ cycle sync operand _ cc wc ca wa acc_sel
// _ wr reg_sel reg_out _ alu_op in0 in1 cin _ pc_sel pc_we pc_ctl
000_010_00000_000_0000_000
000_110_00000_000_0000_000
000_210_00000_000_0000_000
800_310_00000_000_0000_000
500_410_00000_000_0000_000
000_515_01010_000_0002_000
000_615_00000_000_0000_000
000_705_00000_000_0000_000
000_015_00000_000_0000_000
000_115_00000_000_0000_000
000_215_00000_000_0000_000
500_315_00000_000_0000_000
300_415_00000_000_0000_000
000_513_00000_000_0000_000
000_613_00000_000_0000_000
000_703_00000_000_0000_000
000_013_00000_000_0000_000
000_113_00000_000_0000_000
000_213_00000_000_0000_001
A00_313_00000_000_0000_020
700_413_00000_000_0000_010
000_513_00000_000_0000_140
000_613_00000_000_0000_000
000_703_00000_000_0000_000
000_013_00000_000_0000_000
000_113_00000_000_0000_000
000_213_00000_000_0000_000
300_313_00000_000_0000_000
300_413_00000_000_0000_000
000_513_00000_000_0000_210
000_612_00000_000_0000_220
000_703_00000_000_0000_000

//--- tb/cpu_control_assertions.sv
`timescale 1ns/1ps

module cpu_control_assertions (
    input logic clock,
    input logic reset,
    input logic sync,
    input cpu_pkg::phase_t cycle,
    input logic clear_carry,
    input logic write_carry,
    input logic clear_accumulator,
    input logic write_accumulator,
    input logic write_register,
    input logic reg_out_enable,
    input cpu_pkg::pc_nibble_t pc_write_enable,
    input cpu_pkg::pc_stack_op_t pc_control
);
    import cpu_pkg::*;

    // Own subcycle count, A1 after reset and one step per clock
    logic [2:0] expected_phase;

    always_ff @(posedge clock) begin
        if (reset) begin
            expected_phase <= 3'd0;
        end else begin
            expected_phase <= expected_phase + 3'd1;
        end
    end

    // Sync marks the last subcycle only
    sync_low_in_x3: assert property (@(posedge clock) disable iff (reset)
        (!sync) == (expected_phase == X3))
        else $error("sync does not match phase X3");

    // Only one PC nibble is written at a time
    pc_write_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(pc_write_enable))
        else $error("more than one PC nibble enabled");

    acc_write_clear_excl: assert property (@(posedge clock) disable iff (reset)
        !(write_accumulator && clear_accumulator))
        else $error("accumulator written and cleared together");

    // First cycle after reset is a NOP decode
    idle_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> !(clear_carry || write_carry || clear_accumulator ||
            write_accumulator || write_register || reg_out_enable ||
            (pc_write_enable != '0) || (pc_control != STACK_NOP)))
        else $error("strobes active right after reset");

endmodule

bind cpu_control cpu_control_assertions u_assertions (.*);

//--- tb/cpu_control_tb.sv
`timescale 1ns/1ps

module cpu_control_tb;
    import cpu_pkg::*;

    localparam int MAX_LINES = 64;
    localparam int RESET_CYCLES = 10;

    logic clock;
    logic reset;
    nibble_t data;
    logic take_branch;
    logic reg_is_zero;
    logic sync;
    phase_t cycle;
    nibble_t inst_operand;
    logic clear_carry;
    logic write_carry;
    logic clear_accumulator;
    logic write_accumulator;
    acc_in_sel_t acc_input_sel;
    logic write_register;
    reg_in_sel_t reg_input_sel;
    alu_op_t alu_op;
    alu_in0_sel_t alu_in0_sel;
    alu_in1_sel_t alu_in1_sel;
    alu_cin_sel_t alu_cin_sel;
    pc_next_sel_t pc_next_sel;
    pc_nibble_t pc_write_enable;
    pc_stack_op_t pc_control;
    logic reg_out_enable;

    logic [83:0] patterns [0:MAX_LINES-1];
    int line_count;
    int cycle_limit = 1000;
    int cycles = 0;

    clock_gen u_clock (.clock(clock));

    cpu_control u_dut (.*);

    task automatic fail_now(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string field, input int got, input int exp);
        fail_now($sformatf("FAILED at %0t: %s is %0h, expected %0h", $time, field, got, exp));
    endtask

    task automatic check_phase(input phase_t got, input phase_t exp);
        if (got !== exp) report_mismatch("cycle", got, exp);
    endtask

    task automatic check_nibble(input string field, input nibble_t got, input nibble_t exp);
        if (got !== exp) report_mismatch(field, got, exp);
    endtask

    task automatic check_strobe(input string field, input logic got, input logic exp);
        if (got !== exp) report_mismatch(field, got, exp);
    endtask

    task automatic check_alu(input alu_op_t op, input alu_op_t op_exp,
                             input alu_in0_sel_t in0, input alu_in0_sel_t in0_exp,
                             input alu_in1_sel_t in1, input alu_in1_sel_t in1_exp,
                             input alu_cin_sel_t cin, input alu_cin_sel_t cin_exp);
        if (op !== op_exp) report_mismatch("alu_op", op, op_exp);
        if (in0 !== in0_exp) report_mismatch("alu_in0_sel", in0, in0_exp);
        if (in1 !== in1_exp) report_mismatch("alu_in1_sel", in1, in1_exp);
        if (cin !== cin_exp) report_mismatch("alu_cin_sel", cin, cin_exp);
    endtask

    task automatic check_acc_sel(input acc_in_sel_t got, input acc_in_sel_t exp);
        if (got !== exp) report_mismatch("acc_input_sel", got, exp);
    endtask

    task automatic check_reg_sel(input reg_in_sel_t got, input reg_in_sel_t exp);
        if (got !== exp) report_mismatch("reg_input_sel", got, exp);
    endtask

    task automatic check_pc(input pc_nibble_t we, input pc_nibble_t we_exp,
                            input pc_next_sel_t sel, input pc_next_sel_t sel_exp,
                            input pc_stack_op_t op, input pc_stack_op_t op_exp);
        if (we !== we_exp) report_mismatch("pc_write_enable", we, we_exp);
        if (sel !== sel_exp) report_mismatch("pc_next_sel", sel, sel_exp);
        if (op !== op_exp) report_mismatch("pc_control", op, op_exp);
    endtask

    task automatic check_line(input logic [83:0] p);
        check_phase(cycle, phase_t'(p[70:68]));
        check_strobe("sync", sync, p[64]);
        check_nibble("inst_operand", inst_operand, p[63:60]);
        check_strobe("clear_carry", clear_carry, p[56]);
        check_strobe("write_carry", write_carry, p[52]);
        check_strobe("clear_accumulator", clear_accumulator, p[48]);
        check_strobe("write_accumulator", write_accumulator, p[44]);
        check_acc_sel(acc_input_sel, acc_in_sel_t'(p[42:40]));
        check_strobe("write_register", write_register, p[36]);
        check_reg_sel(reg_input_sel, reg_in_sel_t'(p[33:32]));
        check_strobe("reg_out_enable", reg_out_enable, p[28]);
        check_alu(alu_op, alu_op_t'(p[26:24]), alu_in0_sel, alu_in0_sel_t'(p[22:20]),
                  alu_in1_sel, alu_in1_sel_t'(p[17:16]), alu_cin_sel, alu_cin_sel_t'(p[13:12]));
        check_pc(pc_write_enable, p[6:4], pc_next_sel, pc_next_sel_t'(p[9:8]),
                 pc_control, pc_stack_op_t'(p[1:0]));
    endtask

    // Run limit in clocks
    always @(posedge clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            fail_now("Timeout: the pattern run did not finish in time");
        end
    end

    initial begin
        int fd;
        string text;

        reset = 1'b1;
        data = '0;
        take_branch = 1'b0;
        reg_is_zero = 1'b0;

        fd = $fopen("tb/control_patterns.txt", "r");
        if (fd == 0) begin
            fail_now("Could not open the pattern file tb/control_patterns.txt");
        end
        // Data lines only, comments and blank lines skipped
        line_count = 0;
        while ($fgets(text, fd) > 0) begin
            if (text.len() > 2 && text.substr(0, 1) != "//") begin
                line_count++;
            end
        end
        $fclose(fd);
        if (line_count == 0) begin
            fail_now("The pattern file holds no usable lines");
        end
        if (line_count > MAX_LINES) begin
            fail_now("The pattern file holds more lines than the testbench can store");
        end
        $readmemh("tb/control_patterns.txt", patterns);
        cycle_limit = line_count + RESET_CYCLES + 20;

        repeat (RESET_CYCLES) @(posedge clock);
        for (int i = 0; i < line_count; i++) begin
            if (i > 0) begin
                @(posedge clock);
            end
            #2;
            reset = 1'b0;
            data = patterns[i][83:80];
            take_branch = patterns[i][76];
            reg_is_zero = patterns[i][72];
            // Sample just before the next rising edge
            #17;
            check_line(patterns[i]);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
